//--- logic/hps_cfg.svh
`ifndef HPS_CFG_SVH
`define HPS_CFG_SVH

// clocks io_wait stays up once a word is taken downstream
`define HPS_WAIT_CYCLES 8

`define HPS_EVQ_DEPTH 4 // keyboard/mouse event slots

`endif

//--- logic/hps_pkg.sv
package hps_pkg;

	// host opcodes, first byte of a transfer
	typedef enum logic [7:0] {
		CMD_NOP        = 8'h00,
		CMD_BUTTONS    = 8'h01,
		CMD_JOY0       = 8'h02,
		CMD_JOY1       = 8'h03,
		CMD_MOUSE      = 8'h04,
		CMD_KBD        = 8'h05,
		CMD_OSD_KBD    = 8'h06,
		CMD_JOY2       = 8'h10,
		CMD_JOY3       = 8'h11,
		CMD_RTC        = 8'h22,
		CMD_VIDEO_INFO = 8'h23,
		CMD_STATUS     = 8'h25,
		CMD_PING       = 8'h2B
	} hps_cmd_e;

	typedef enum logic [1:0] {
		MOUSE_X = 2'd0,
		MOUSE_Y = 2'd1,
		KEY     = 2'd2,
		OSD_KEY = 2'd3
	} kms_kind_e;

	typedef struct packed {
		hps_cmd_e    cmd;
		logic [5:0]  idx;  // 0 = command word, sticks at 63
		logic [15:0] data;
	} host_word_t;

	typedef struct packed {
		kms_kind_e  kind;
		logic [7:0] data;
	} kms_event_t;

	typedef struct packed {
		logic [15:0] width;
		logic [15:0] height;
		logic [31:0] period; // clk_100 cycles per frame
		logic [7:0]  nres;
	} vid_meas_t;

	typedef struct packed {
		logic [1:0] buttons;
		logic [3:0] conf;
		logic [2:0] mouse_buttons;
		logic [2:0] evq_level;
	} input_state_t;

endpackage

//--- logic/host_framer.sv
`timescale 1ns/1ps
`include "hps_cfg.svh"

module host_framer (
	input  logic                clk_100,
	input  logic                reset,
	input  logic                io_ena,
	input  logic                io_strobe,
	input  logic [15:0]         io_din,
	input  logic                word_ready,
	output logic                word_valid,
	output hps_pkg::host_word_t word,
	output logic                io_wait
);
	localparam int WAIT_W = $clog2(`HPS_WAIT_CYCLES + 1);

	hps_pkg::hps_cmd_e cmd; // opcode of the running transfer
	logic [5:0] cnt;
	logic [WAIT_W-1:0] wait_cnt;
	logic take;

	assign take = io_ena && io_strobe && !io_wait;

	// opcode latch and word numbering
	always_ff @(posedge clk_100) begin
		if (reset) begin
			cmd <= hps_pkg::CMD_NOP;
			cnt <= 6'd0;
		end else if (!io_ena) begin
			cmd <= hps_pkg::CMD_NOP;
			cnt <= 6'd0;
		end else if (take) begin
			if (cnt == 6'd0) begin
				cmd <= hps_pkg::hps_cmd_e'(io_din[7:0]);
			end
			if (cnt != 6'd63) begin
				cnt <= cnt + 6'd1;
			end
		end
	end

	always_ff @(posedge clk_100) begin
		if (take) begin
			word.cmd <= (cnt == 6'd0) ? hps_pkg::hps_cmd_e'(io_din[7:0]) : cmd;
			word.idx <= cnt;
			word.data <= io_din;
		end
	end

	// hold the word until taken, then run out the wait window
	always_ff @(posedge clk_100) begin
		if (reset) begin
			word_valid <= 1'b0;
			io_wait <= 1'b0;
			wait_cnt <= '0;
		end else if (take) begin
			word_valid <= 1'b1;
			io_wait <= 1'b1;
		end else if (word_valid) begin
			if (word_ready) begin
				word_valid <= 1'b0;
				wait_cnt <= WAIT_W'(`HPS_WAIT_CYCLES);
			end
		end else if (wait_cnt != '0) begin
			wait_cnt <= wait_cnt - WAIT_W'(1);
			if (wait_cnt == WAIT_W'(1)) begin
				io_wait <= 1'b0; // last clock of the window
			end
		end
	end

endmodule

//--- logic/input_regs.sv
`timescale 1ns/1ps
`include "hps_cfg.svh"

module input_regs (
	input  logic                  clk_100,
	input  logic                  reset,
	input  logic                  word_valid,
	input  hps_pkg::host_word_t   word,
	input  logic                  kms_ready,
	output logic                  word_ready,
	output logic [15:0]           joy0,
	output logic [15:0]           joy1,
	output logic [15:0]           joy2,
	output logic [15:0]           joy3,
	output logic [63:0]           rtc,
	output hps_pkg::input_state_t state,
	output logic                  kms_valid,
	output hps_pkg::kms_event_t   kms
);
	localparam int DEPTH = `HPS_EVQ_DEPTH;
	localparam int PTR_W = $clog2(DEPTH);

	hps_pkg::kms_event_t evq [DEPTH];
	logic [PTR_W-1:0] wr_ptr;
	logic [PTR_W-1:0] rd_ptr;
	logic [2:0] level;
	logic [1:0] buttons;
	logic [3:0] conf;
	logic [2:0] mouse_buttons;
	logic ev_word;
	hps_pkg::kms_kind_e ev_kind;
	logic accept;
	logic push;
	logic pop;

	function automatic logic [PTR_W-1:0] next_ptr(input logic [PTR_W-1:0] p);
		return (p == PTR_W'(DEPTH - 1)) ? '0 : p + PTR_W'(1);
	endfunction

	// words that carry a keyboard or mouse event
	always_comb begin
		ev_word = 1'b0;
		ev_kind = hps_pkg::KEY;
		case (word.cmd)
			hps_pkg::CMD_MOUSE: begin
				ev_word = (word.idx == 6'd1) || (word.idx == 6'd2);
				ev_kind = (word.idx == 6'd2) ? hps_pkg::MOUSE_Y : hps_pkg::MOUSE_X;
			end
			hps_pkg::CMD_KBD: begin
				ev_word = word.idx == 6'd1;
				ev_kind = hps_pkg::KEY;
			end
			hps_pkg::CMD_OSD_KBD: begin
				ev_word = word.idx == 6'd1;
				ev_kind = hps_pkg::OSD_KEY;
			end
			default: ;
		endcase
	end

	assign word_ready = !(ev_word && level == 3'(DEPTH)); // stall on full queue
	assign accept = word_valid && word_ready;
	assign push = accept && ev_word;
	assign pop = kms_valid && kms_ready;
	assign kms_valid = level != 3'd0;
	assign kms = evq[rd_ptr];

	always_ff @(posedge clk_100) begin
		if (push) begin
			evq[wr_ptr] <= '{kind: ev_kind, data: word.data[7:0]};
		end
	end

	always_ff @(posedge clk_100) begin
		if (reset) begin
			wr_ptr <= '0;
			rd_ptr <= '0;
			level <= 3'd0;
		end else begin
			if (push) begin
				wr_ptr <= next_ptr(wr_ptr);
			end
			if (pop) begin
				rd_ptr <= next_ptr(rd_ptr);
			end
			level <= level + 3'(push) - 3'(pop);
		end
	end

	// register writes
	always_ff @(posedge clk_100) begin
		if (reset) begin
			buttons <= 2'd0;
			conf <= 4'd0;
			mouse_buttons <= 3'd0;
			joy0 <= 16'd0;
			joy1 <= 16'd0;
			joy2 <= 16'd0;
			joy3 <= 16'd0;
			rtc <= 64'd0;
		end else if (accept) begin
			if (word.idx == 6'd1) begin
				case (word.cmd)
					hps_pkg::CMD_BUTTONS: begin
						buttons <= word.data[1:0];
						conf <= word.data[7:4];
					end
					hps_pkg::CMD_JOY0: joy0 <= word.data;
					hps_pkg::CMD_JOY1: joy1 <= word.data;
					hps_pkg::CMD_JOY2: joy2 <= word.data;
					hps_pkg::CMD_JOY3: joy3 <= word.data;
					default: ;
				endcase
			end
			if (word.cmd == hps_pkg::CMD_MOUSE && word.idx == 6'd3) begin
				mouse_buttons <= word.data[2:0];
			end
			if (word.cmd == hps_pkg::CMD_RTC) begin
				case (word.idx) // low slice first
					6'd1: rtc[15:0] <= word.data;
					6'd2: rtc[31:16] <= word.data;
					6'd3: rtc[47:32] <= word.data;
					6'd4: rtc[63:48] <= word.data;
					default: ;
				endcase
			end
		end
	end

	assign state = '{
		buttons: buttons,
		conf: conf,
		mouse_buttons: mouse_buttons,
		evq_level: level
	};

endmodule

//--- logic/video_meter.sv
`timescale 1ns/1ps

module video_meter (
	input  logic               clk_100,
	input  logic               reset,
	input  logic               ce_pix,
	input  logic               de,
	input  logic               hs,
	input  logic               vs,
	output hps_pkg::vid_meas_t meas
);
	logic ce_r;
	logic de_r;
	logic hs_r;
	logic vs_r;
	logic hs_p;
	logic vs_p;
	logic de_p; // de at the previous pixel
	logic calch; // still on the first active line
	logic [15:0] hcnt;
	logic [15:0] vcnt;
	logic [31:0] vtime;
	logic vs_rise;
	logic hs_rise;

	always_ff @(posedge clk_100) begin
		if (reset) begin
			ce_r <= 1'b0;
			de_r <= 1'b0;
			hs_r <= 1'b0;
			vs_r <= 1'b0;
			hs_p <= 1'b0;
			vs_p <= 1'b0;
		end else begin
			ce_r <= ce_pix;
			de_r <= de;
			hs_r <= hs;
			vs_r <= vs;
			hs_p <= hs_r;
			vs_p <= vs_r;
		end
	end

	assign vs_rise = vs_r && !vs_p;
	assign hs_rise = hs_r && !hs_p;

	// pixels of the first line, active lines of the frame
	always_ff @(posedge clk_100) begin
		if (reset) begin
			de_p <= 1'b0;
			calch <= 1'b0;
			hcnt <= 16'd0;
			vcnt <= 16'd0;
		end else if (vs_rise) begin
			hcnt <= 16'd0;
			vcnt <= 16'd0;
			calch <= 1'b1;
		end else begin
			if (ce_r) begin
				de_p <= de_r;
				if (de_r && !de_p) begin
					vcnt <= vcnt + 16'd1;
				end
				if (calch && de_r) begin
					hcnt <= hcnt + 16'd1;
				end
				if (de_p && !de_r) begin
					calch <= 1'b0;
				end
			end
			if (hs_rise && hcnt != 16'd0) begin
				calch <= 1'b0; // line over at hsync too
			end
		end
	end

	always_ff @(posedge clk_100) begin
		if (reset) begin
			meas <= '0;
			vtime <= 32'd0;
		end else if (vs_rise) begin
			vtime <= 32'd0;
			meas.period <= vtime + 32'd1;
			if (hcnt != 16'd0 && vcnt != 16'd0) begin
				if (hcnt != meas.width || vcnt != meas.height) begin
					meas.nres <= meas.nres + 8'd1;
				end
				meas.width <= hcnt;
				meas.height <= vcnt;
			end
		end else begin
			vtime <= vtime + 32'd1;
		end
	end

endmodule

//--- logic/reply_mux.sv
`timescale 1ns/1ps

module reply_mux (
	input  logic                  clk_100,
	input  logic                  reset,
	input  logic                  word_valid,
	input  logic                  word_ready,
	input  hps_pkg::host_word_t   word,
	input  hps_pkg::vid_meas_t    meas,
	input  hps_pkg::input_state_t state,
	output logic [15:0]           io_dout
);
	logic [15:0] reply;

	always_comb begin
		reply = 16'h0000;
		case (word.cmd)
			hps_pkg::CMD_PING: begin
				if (word.idx == 6'd0) begin
					reply = 16'h0001;
				end
			end
			hps_pkg::CMD_VIDEO_INFO: begin
				case (word.idx)
					6'd1: reply = {8'h00, meas.nres};
					6'd2: reply = meas.width;
					6'd3: reply = meas.height;
					6'd4: reply = meas.period[15:0];
					6'd5: reply = meas.period[31:16];
					default: ;
				endcase
			end
			hps_pkg::CMD_STATUS: begin
				if (word.idx == 6'd1) begin
					reply = {4'h0, state.evq_level, state.mouse_buttons,
						state.conf, state.buttons};
				end
			end
			default: ;
		endcase
	end

	always_ff @(posedge clk_100) begin
		if (reset) begin
			io_dout <= 16'h0000;
		end else if (word_valid && word_ready) begin
			io_dout <= reply; // held until the next word
		end
	end

endmodule

//--- logic/hps_io.sv
`timescale 1ns/1ps

module hps_io (
	input  logic                clk_100,
	input  logic                reset,
	input  logic                io_ena,
	input  logic                io_strobe,
	input  logic [15:0]         io_din,
	output logic [15:0]         io_dout,
	output logic                io_wait,
	input  logic                ce_pix,
	input  logic                de,
	input  logic                hs,
	input  logic                vs,
	output logic [15:0]         joy0,
	output logic [15:0]         joy1,
	output logic [15:0]         joy2,
	output logic [15:0]         joy3,
	output logic [63:0]         rtc,
	output logic [1:0]          buttons,
	output logic [3:0]          conf,
	output logic [2:0]          mouse_buttons,
	output logic                kms_valid,
	input  logic                kms_ready,
	output hps_pkg::kms_event_t kms
);
	logic word_valid;
	logic word_ready;
	hps_pkg::host_word_t word;
	hps_pkg::input_state_t state;
	hps_pkg::vid_meas_t meas;

	host_framer u_framer (
		.clk_100    (clk_100),
		.reset      (reset),
		.io_ena     (io_ena),
		.io_strobe  (io_strobe),
		.io_din     (io_din),
		.word_ready (word_ready),
		.word_valid (word_valid),
		.word       (word),
		.io_wait    (io_wait)
	);

	input_regs u_inputs (
		.clk_100    (clk_100),
		.reset      (reset),
		.word_valid (word_valid),
		.word       (word),
		.kms_ready  (kms_ready),
		.word_ready (word_ready),
		.joy0       (joy0),
		.joy1       (joy1),
		.joy2       (joy2),
		.joy3       (joy3),
		.rtc        (rtc),
		.state      (state),
		.kms_valid  (kms_valid),
		.kms        (kms)
	);

	video_meter u_meter (
		.clk_100 (clk_100),
		.reset   (reset),
		.ce_pix  (ce_pix),
		.de      (de),
		.hs      (hs),
		.vs      (vs),
		.meas    (meas)
	);

	reply_mux u_reply (
		.clk_100    (clk_100),
		.reset      (reset),
		.word_valid (word_valid),
		.word_ready (word_ready),
		.word       (word),
		.meas       (meas),
		.state      (state),
		.io_dout    (io_dout)
	);

	assign buttons = state.buttons;
	assign conf = state.conf;
	assign mouse_buttons = state.mouse_buttons;

endmodule

//--- test/hps_io_checker.sv
`timescale 1ns/1ps
`include "hps_cfg.svh"

module hps_io_checker (
	input logic                clk_100,
	input logic                reset,
	input logic                io_wait,
	input logic                word_valid,
	input logic                word_ready,
	input hps_pkg::host_word_t word,
	input logic                kms_valid,
	input logic                kms_ready,
	input hps_pkg::kms_event_t kms,
	input logic [2:0]          evq_level
);

	// handshake outputs idle while in reset
	a_reset_idle: assert property (@(posedge clk_100) reset |=> !io_wait && !kms_valid)
		else $error("io_wait or kms_valid active during reset");

	a_word_hold: assert property (@(posedge clk_100) disable iff (reset)
		word_valid && !word_ready |=> word_valid && $stable(word))
		else $error("host word changed while waiting for word_ready");

	a_kms_hold: assert property (@(posedge clk_100) disable iff (reset)
		kms_valid && !kms_ready |=> kms_valid && $stable(kms))
		else $error("event changed while waiting for kms_ready");

	a_evq_bound: assert property (@(posedge clk_100) disable iff (reset)
		evq_level <= 3'(`HPS_EVQ_DEPTH))
		else $error("event queue level above its depth");

endmodule

bind hps_io hps_io_checker u_checker (
	.clk_100    (clk_100),
	.reset      (reset),
	.io_wait    (io_wait),
	.word_valid (word_valid),
	.word_ready (word_ready),
	.word       (word),
	.kms_valid  (kms_valid),
	.kms_ready  (kms_ready),
	.kms        (kms),
	.evq_level  (state.evq_level)
);

//--- test/hps_io_tb.sv
`timescale 1ns/1ps
`include "hps_cfg.svh"

module hps_io_tb;
	localparam int LIMIT = 4000; // clocks any single wait may take

	logic clk_100 = 1'b0;
	logic reset;
	logic io_ena;
	logic io_strobe;
	logic [15:0] io_din;
	logic [15:0] io_dout;
	logic io_wait;
	logic ce_pix;
	logic de;
	logic hs;
	logic vs;
	logic [15:0] joy0;
	logic [15:0] joy1;
	logic [15:0] joy2;
	logic [15:0] joy3;
	logic [63:0] rtc;
	logic [1:0] buttons;
	logic [3:0] conf;
	logic [2:0] mouse_buttons;
	logic kms_valid;
	logic kms_ready = 1'b0;
	hps_pkg::kms_event_t kms;

	logic hold = 1'b0; // forces kms_ready low
	logic [15:0] tx_q[$];
	logic [15:0] rx_q[$];
	int wait_q[$];
	int last_wait; // clocks of the last io_wait window
	logic [9:0] ev_exp[$]; // {kind, data} in expected order

	// reference model
	logic [1:0] m_buttons;
	logic [3:0] m_conf;
	logic [2:0] m_mbtn;
	logic [15:0] m_joy[4];
	logic [63:0] m_rtc;
	int m_width;
	int m_height;
	int m_period;
	int m_nres;

	hps_io DUT (.*);

	always #10 clk_100 = ~clk_100;

	always @(posedge clk_100) begin
		kms_ready <= !hold && ($urandom % 4 != 0); // core takes events now and then
	end

	task automatic stop_with_failure(input string why);
		$display("%s", why);
		$display("Verification failed");
		$fatal(1, "simulation stopped at the first error");
	endtask

	task automatic check_value(input string name, input logic [63:0] got,
		input logic [63:0] exp);
		if (got !== exp) begin
			stop_with_failure($sformatf("[ERROR] %s: got 0x%0h, expected 0x%0h",
				name, got, exp));
		end
	endtask

	// events leave on the next posedge when valid and ready now
	always @(negedge clk_100) begin
		if (!reset && kms_valid && kms_ready) begin
			if (ev_exp.size() == 0) begin
				stop_with_failure($sformatf("the DUT sent event 0x%0h that was never queued",
					kms));
			end else begin
				check_value("kms", 64'(kms), 64'(ev_exp.pop_front()));
			end
		end
	end

	task automatic wait_io_idle();
		int t;
		t = 0;
		@(negedge clk_100);
		while (io_wait) begin
			t++;
			if (t > LIMIT) begin
				stop_with_failure("timeout: io_wait stayed high and the word was never taken");
			end
			@(negedge clk_100);
		end
		last_wait = t;
	endtask

	task automatic send_word(input logic [15:0] w);
		wait_io_idle();
		@(posedge clk_100);
		io_strobe <= 1'b1;
		io_din <= w;
		@(posedge clk_100);
		io_strobe <= 1'b0;
	endtask

	// whole transfer from tx_q with replies into rx_q
	task automatic run_transfer();
		rx_q.delete();
		wait_q.delete();
		@(posedge clk_100);
		io_ena <= 1'b1;
		foreach (tx_q[i]) begin
			send_word(tx_q[i]);
			wait_io_idle();
			rx_q.push_back(io_dout);
			wait_q.push_back(last_wait);
		end
		@(posedge clk_100);
		io_ena <= 1'b0;
	endtask

	task automatic drain_events();
		int t;
		t = 0;
		@(negedge clk_100);
		while (kms_valid || ev_exp.size() != 0) begin
			t++;
			if (t > LIMIT) begin
				stop_with_failure("timeout: queued keyboard/mouse events never came out");
			end
			@(negedge clk_100);
		end
	endtask

	// one frame at two clocks per pixel with vsync on line 0
	task automatic play_frame(input int w, input int h);
		for (int ln = 0; ln < h + 3; ln++) begin
			for (int px = 0; px < w + 12; px++) begin
				@(posedge clk_100);
				ce_pix <= 1'b1;
				vs <= (ln == 0);
				hs <= (px < 4);
				de <= (ln >= 3) && (px >= 8) && (px < w + 8);
				@(posedge clk_100);
				ce_pix <= 1'b0;
			end
		end
	endtask

	task automatic check_regs();
		check_value("buttons", 64'(buttons), 64'(m_buttons));
		check_value("conf", 64'(conf), 64'(m_conf));
		check_value("mouse_buttons", 64'(mouse_buttons), 64'(m_mbtn));
		check_value("joy0", 64'(joy0), 64'(m_joy[0]));
		check_value("joy1", 64'(joy1), 64'(m_joy[1]));
		check_value("joy2", 64'(joy2), 64'(m_joy[2]));
		check_value("joy3", 64'(joy3), 64'(m_joy[3]));
		check_value("rtc", rtc, m_rtc);
	endtask

	function automatic logic [15:0] joy_opcode(input int i);
		case (i)
			0: return 16'(hps_pkg::CMD_JOY0);
			1: return 16'(hps_pkg::CMD_JOY1);
			2: return 16'(hps_pkg::CMD_JOY2);
			default: return 16'(hps_pkg::CMD_JOY3);
		endcase
	endfunction

	// buttons, conf, mouse buttons, queue level from bit 0 up
	function automatic logic [15:0] status_word(input int level);
		return 16'(m_buttons) | (16'(m_conf) << 2) | (16'(m_mbtn) << 6) | (16'(level) << 9);
	endfunction

	initial begin
		int sel;
		int k;
		int vw;
		logic [15:0] d;
		logic [15:0] d2;
		logic [15:0] d3;

		void'($urandom(32'hb0b048e1));
		reset = 1'b1;
		io_ena = 1'b0;
		io_strobe = 1'b0;
		io_din = 16'h0000;
		ce_pix = 1'b0;
		de = 1'b0;
		hs = 1'b0;
		vs = 1'b0;
		m_buttons = 2'd0;
		m_conf = 4'd0;
		m_mbtn = 3'd0;
		m_rtc = 64'd0;
		foreach (m_joy[i]) m_joy[i] = 16'h0000;
		m_width = 0;
		m_height = 0;
		m_nres = 0;
		vw = 0;
		repeat (8) @(posedge clk_100);
		reset <= 1'b0;
		@(negedge clk_100);
		check_value("io_wait", 64'(io_wait), 64'd0);
		check_value("kms_valid", 64'(kms_valid), 64'd0);
		check_value("io_dout", 64'(io_dout), 64'd0);
		check_regs();

		// register writes
		for (int n = 0; n < 40; n++) begin
			sel = $urandom % 6;
			d = 16'($urandom);
			tx_q.delete();
			if (sel == 0) begin
				tx_q.push_back(16'(hps_pkg::CMD_BUTTONS));
				tx_q.push_back(d);
				m_buttons = d[1:0];
				m_conf = d[7:4];
			end else if (sel < 5) begin
				tx_q.push_back(joy_opcode(sel - 1));
				tx_q.push_back(d);
				m_joy[sel - 1] = d;
			end else begin
				tx_q.push_back(16'(hps_pkg::CMD_RTC));
				for (int s = 0; s < 4; s++) begin
					d = 16'($urandom);
					tx_q.push_back(d);
					m_rtc[16*s +: 16] = d;
				end
			end
			run_transfer();
			foreach (rx_q[i]) begin
				check_value("io_dout", 64'(rx_q[i]), 64'd0);
				check_value("io_wait cycles", 64'(wait_q[i]), 64'(`HPS_WAIT_CYCLES + 1));
			end
			check_regs();
		end

		// keyboard, mouse, osd events
		for (int n = 0; n < 30; n++) begin
			sel = $urandom % 3;
			d = 16'($urandom);
			d2 = 16'($urandom);
			d3 = 16'($urandom);
			tx_q.delete();
			if (sel == 0) begin
				tx_q = '{16'(hps_pkg::CMD_MOUSE), d, d2, d3};
				ev_exp.push_back({hps_pkg::MOUSE_X, d[7:0]});
				ev_exp.push_back({hps_pkg::MOUSE_Y, d2[7:0]});
				m_mbtn = d3[2:0];
			end else if (sel == 1) begin
				tx_q = '{16'(hps_pkg::CMD_KBD), d};
				ev_exp.push_back({hps_pkg::KEY, d[7:0]});
			end else begin
				tx_q = '{16'(hps_pkg::CMD_OSD_KBD), d};
				ev_exp.push_back({hps_pkg::OSD_KEY, d[7:0]});
			end
			run_transfer();
			check_regs();
		end
		drain_events();

		// full queue stalls the host
		hold = 1'b1;
		for (int n = 0; n < `HPS_EVQ_DEPTH; n++) begin
			d = 16'($urandom);
			tx_q = '{16'(hps_pkg::CMD_KBD), d};
			ev_exp.push_back({hps_pkg::KEY, d[7:0]});
			run_transfer();
		end
		d = 16'($urandom);
		ev_exp.push_back({hps_pkg::KEY, d[7:0]});
		@(posedge clk_100);
		io_ena <= 1'b1;
		send_word(16'(hps_pkg::CMD_KBD));
		wait_io_idle();
		send_word(d);
		repeat (40) begin
			@(negedge clk_100);
			check_value("io_wait", 64'(io_wait), 64'd1);
			check_value("kms_valid", 64'(kms_valid), 64'd1);
		end
		hold = 1'b0;
		wait_io_idle();
		@(posedge clk_100);
		io_ena <= 1'b0;
		drain_events();

		// ping and status with a known queue level
		for (int n = 0; n < 10; n++) begin
			drain_events();
			hold = 1'b1;
			k = $urandom % (`HPS_EVQ_DEPTH + 1);
			for (int e = 0; e < k; e++) begin
				d = 16'($urandom);
				tx_q = '{16'(hps_pkg::CMD_KBD), d};
				ev_exp.push_back({hps_pkg::KEY, d[7:0]});
				run_transfer();
			end
			tx_q = '{16'(hps_pkg::CMD_PING)};
			run_transfer();
			check_value("io_dout ping", 64'(rx_q[0]), 64'd1);
			tx_q = '{16'(hps_pkg::CMD_STATUS), 16'h0000};
			run_transfer();
			check_value("io_dout status", 64'(rx_q[1]), 64'(status_word(k)));
			@(negedge clk_100);
			hold = 1'b0;
		end
		drain_events();

		// video timing over two frames per size
		for (int n = 0; n < 6; n++) begin
			if (n == 0 || $urandom % 3 != 0) begin
				vw = 8 + $urandom % 33;
				k = 4 + $urandom % 9;
			end
			if (vw != m_width || k != m_height) begin
				m_nres++;
			end
			m_width = vw;
			m_height = k;
			m_period = 2 * (vw + 12) * (k + 3);
			repeat (2) play_frame(vw, k);
			tx_q = '{16'(hps_pkg::CMD_VIDEO_INFO), 16'h0000, 16'h0000, 16'h0000,
				16'h0000, 16'h0000};
			run_transfer();
			check_value("nres", 64'(rx_q[1]), 64'(m_nres));
			check_value("width", 64'(rx_q[2]), 64'(m_width));
			check_value("height", 64'(rx_q[3]), 64'(m_height));
			check_value("period lo", 64'(rx_q[4]), 64'(m_period & 32'hffff));
			check_value("period hi", 64'(rx_q[5]), 64'(m_period >> 16));
		end

		@(negedge clk_100);
		if (ev_exp.size() != 0 || kms_valid) begin
			stop_with_failure("events left over at the end of the run");
		end else begin
			$display("Verification passed");
			$finish;
		end
	end

endmodule

//--- src.f
+incdir+logic
logic/hps_pkg.sv
logic/host_framer.sv
logic/input_regs.sv
logic/video_meter.sv
logic/reply_mux.sv
logic/hps_io.sv
test/hps_io_checker.sv
test/hps_io_tb.sv

//--- run.sh
#!/bin/sh
# build and run the hps_io testbench with Verilator

cd "$(dirname "$0")" || exit 1

LOG=sim.log

rm -rf obj_dir
verilator --binary --timing --assert -f src.f --top-module hps_io_tb -o hps_io_sim
if [ $? -ne 0 ]; then
	echo "build failed"
	exit 1
fi

./obj_dir/hps_io_sim > "$LOG" 2>&1
status=$?
cat "$LOG"

# the log decides
if grep -q "Verification failed" "$LOG"; then
	echo "simulation reported a failure"
	exit 1
fi
if [ $status -ne 0 ]; then
	echo "simulation exited with status $status"
	exit 1
fi
if ! grep -q "Verification passed" "$LOG"; then
	echo "simulation ended without a result"
	exit 1
fi
exit 0
